// File: decode_top.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/prefix_opcode_stage.sv
verilog/modrm_length_stage.sv
verilog/eip_stage.sv
verilog/credit_pool.sv
verilog/decode_top.sv
sim/decode_sva.sv
sim/decode_tb.sv

// File: sim/decode_stimulus.txt
// kind packet(byte 0 first) len disp imm rep opsize seg_valid seg bad
// kind 0 packet, 1 redirect (target in the packet column), 2 end of records
0 90CCCCCCCCCCCCCCCCCCCCCCCCCCCCCC 1 00000000 00000000 0 0 0 0 0
0 C3CCCCCCCCCCCCCCCCCCCCCCCCCCCCCC 1 00000000 00000000 0 0 0 0 0
0 0578563412CCCCCCCCCCCCCCCCCCCCCC 5 00000000 12345678 0 0 0 0 0
0 BBEFBEADDECCCCCCCCCCCCCCCCCCCCCC 5 00000000 DEADBEEF 0 0 0 0 0
0 E91000000000CCCCCCCCCCCCCCCCCCCC 5 00000000 00000010 0 0 0 0 0
0 EBFECCCCCCCCCCCCCCCCCCCCCCCCCCCC 2 00000000 FFFFFFFE 0 0 0 0 0
0 01C8CCCCCCCCCCCCCCCCCCCCCCCCCCCC 2 00000000 00000000 0 0 0 0 0
0 8B03CCCCCCCCCCCCCCCCCCCCCCCCCCCC 2 00000000 00000000 0 0 0 0 0
0 8945F8CCCCCCCCCCCCCCCCCCCCCCCCCC 3 FFFFFFF8 00000000 0 0 0 0 0
0 8B8B00100000CCCCCCCCCCCCCCCCCCCC 6 00001000 00000000 0 0 0 0 0
0 8B0544332211CCCCCCCCCCCCCCCCCCCC 6 11223344 00000000 0 0 0 0 0
0 8B0488CCCCCCCCCCCCCCCCCCCCCCCCCC 3 00000000 00000000 0 0 0 0 0
1 00400000 0 00000000 00000000 0 0 0 0 0
0 89442408CCCCCCCCCCCCCCCCCCCCCCCC 4 00000008 00000000 0 0 0 0 0
0 8B04AD00200000CCCCCCCCCCCCCCCCCC 7 00002000 00000000 0 0 0 0 0
0 8B84C878563412CCCCCCCCCCCCCCCCCC 7 12345678 00000000 0 0 0 0 0
0 C70001000000CCCCCCCCCCCCCCCCCCCC 6 00000000 00000001 0 0 0 0 0
0 C745FC0A000000CCCCCCCCCCCCCCCCCC 7 FFFFFFFC 0000000A 0 0 0 0 0
0 81842400010000FFFFFF7FCCCCCCCCCC B 00000100 7FFFFFFF 0 0 0 0 0
0 83C080CCCCCCCCCCCCCCCCCCCCCCCCCC 3 00000000 FFFFFF80 0 0 0 0 0
0 836D1005CCCCCCCCCCCCCCCCCCCCCCCC 4 00000010 00000005 0 0 0 0 0
0 0FAFC1CCCCCCCCCCCCCCCCCCCCCCCCCC 3 00000000 00000000 0 0 0 0 0
0 0FAF0500000080CCCCCCCCCCCCCCCCCC 7 80000000 00000000 0 0 0 0 0
0 66053412CCCCCCCCCCCCCCCCCCCCCCCC 4 00000000 00001234 0 1 0 0 0
0 66B8FFFFCCCCCCCCCCCCCCCCCCCCCCCC 4 00000000 0000FFFF 0 1 0 0 0
0 66C7003412CCCCCCCCCCCCCCCCCCCCCC 5 00000000 00001234 0 1 0 0 0
0 F390CCCCCCCCCCCCCCCCCCCCCCCCCCCC 2 00000000 00000000 1 0 0 0 0
1 7FFF0000 0 00000000 00000000 0 0 0 0 0
0 2E8B03CCCCCCCCCCCCCCCCCCCCCCCCCC 3 00000000 00000000 0 0 1 1 0
0 648B0500000000CCCCCCCCCCCCCCCCCC 7 00000000 00000000 0 0 1 4 0
0 F3666581C33412CCCCCCCCCCCCCCCCCC 7 00000000 00001234 1 1 1 5 0
0 263E36894508CCCCCCCCCCCCCCCCCCCC 6 00000008 00000000 0 0 1 2 0
0 3E0FAF4424F0CCCCCCCCCCCCCCCCCCCC 6 FFFFFFF0 00000000 0 0 1 3 0
0 0F05CCCCCCCCCCCCCCCCCCCCCCCCCCCC 1 00000000 00000000 0 0 0 0 1
0 FF00CCCCCCCCCCCCCCCCCCCCCCCCCCCC 1 00000000 00000000 0 0 0 0 1
0 66F4CCCCCCCCCCCCCCCCCCCCCCCCCCCC 1 00000000 00000000 0 1 0 0 1
0 65C3CCCCCCCCCCCCCCCCCCCCCCCCCCCC 2 00000000 00000000 0 0 1 5 0
2 0 0 0 0 0 0 0 0 0

// File: sim/decode_tb.sv
`include "decode_config.svh"

module decode_tb;

    localparam int MAX_RECS   = 64;
    localparam int FIELDS     = 10;    // words per record
    localparam int F_KIND     = 0;
    localparam int F_PKT      = 1;     // also the redirect target
    localparam int F_LEN      = 2;
    localparam int F_DISP     = 3;
    localparam int F_IMM      = 4;
    localparam int F_REP      = 5;
    localparam int F_OPS      = 6;
    localparam int F_SEGV     = 7;
    localparam int F_SEG      = 8;
    localparam int F_BAD      = 9;
    localparam int KIND_PKT   = 0;
    localparam int KIND_REDIR = 1;
    localparam int KIND_END   = 2;
    localparam int DEPTH      = `DEC_QUEUE_DEPTH;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    decode_pkg::packet_t   in_packet;
    logic                  in_credit;
    logic                  redirect_valid;
    logic [`DEC_EIP_W-1:0] redirect_eip;
    logic                  out_valid;
    decode_pkg::decoded_t  out_item;
    logic                  out_credit;

    decode_pkg::packet_t   stim [0:MAX_RECS*FIELDS-1];  // one field per word
    int                    exp_q[$];       // record numbers in flight in send order
    logic [`DEC_EIP_W-1:0] exp_eip;        // eip of the next output
    int                    seed;
    int                    num_recs;
    logic                  loaded;
    int                    credits_got;    // in_credit pulses seen
    int                    credits_ret;    // out_credit pulses driven
    int                    pkts_sent;
    int                    outputs_got;
    int                    cycle_cnt;

    decode_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_packet      (in_packet),
        .in_credit      (in_credit),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .out_valid      (out_valid),
        .out_item       (out_item),
        .out_credit     (out_credit)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string field, input int rec,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            abort_run($sformatf("MISMATCH rec%0d_%s expected %h actual %h",
                                rec, field, expected, actual));
        end
    endtask

    function automatic logic [31:0] field_of(input int rec, input int idx);
        return stim[rec*FIELDS + idx][31:0];
    endfunction

    ////////////////////
    // output checks
    ////////////////////

    // compare each output against its record
    always @(posedge clk) begin : check_outputs
        int rec;
        if (in_credit) begin
            credits_got++;
        end
        if (rst_n && out_valid) begin
            assert (exp_q.size() > 0) else abort_run("an output appeared with no packet sent");
            rec = exp_q.pop_front();
            check_value("length", rec, field_of(rec, F_LEN), out_item.length);
            check_value("disp", rec, field_of(rec, F_DISP), out_item.disp);
            check_value("imm", rec, field_of(rec, F_IMM), out_item.imm);
            check_value("rep", rec, field_of(rec, F_REP), out_item.prefix.rep);
            check_value("opsize", rec, field_of(rec, F_OPS), out_item.prefix.opsize);
            check_value("seg_valid", rec, field_of(rec, F_SEGV), out_item.prefix.seg_valid);
            check_value("seg", rec, field_of(rec, F_SEG), out_item.prefix.seg);
            check_value("bad_opcode", rec, field_of(rec, F_BAD), out_item.bad_opcode);
            check_value("eip", rec, exp_eip, out_item.eip);
            exp_eip = exp_eip + field_of(rec, F_LEN);   // next instr starts here
            outputs_got++;
        end
        assert (outputs_got - credits_ret <= DEPTH)
            else abort_run("the queue holds more items than its depth");
        assert (pkts_sent - credits_ret <= DEPTH)
            else abort_run("more packets in flight than queue slots");
        assert (credits_got - credits_ret <= DEPTH)
            else abort_run("in_credit kept coming while the queue was full");
        assert (i_dut.i_decode_sva.fail_count == 0)
            else abort_run("a bound assertion on the handshake failed");
    end

    ////////////////////
    // queue model
    ////////////////////

    always begin : queue_model
        logic withhold;
        @(posedge clk);
        #1;
        cycle_cnt++;
        withhold   = (cycle_cnt % 80) >= 50;   // long stall lets the pool run dry
        out_credit = 1'b0;
        if (rst_n && !withhold && outputs_got > credits_ret && ($random(seed) & 1)) begin
            out_credit = 1'b1;   // one slot drained
            credits_ret++;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (num_recs * 40 + 200) @(posedge clk);
        abort_run("timeout, the run did not finish in time");
    end

    ////////////////////
    // driver
    ////////////////////

    initial begin : driver
        int rec;
        int gap;
        int kind;
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_packet      = '0;
        redirect_valid = 1'b0;
        redirect_eip   = '0;
        out_credit     = 1'b0;
        seed           = 47;
        exp_eip        = '0;   // eip after reset
        credits_got    = 0;
        credits_ret    = 0;
        pkts_sent      = 0;
        outputs_got    = 0;
        cycle_cnt      = 0;
        num_recs       = 0;
        loaded         = 1'b0;
        $readmemh("sim/decode_stimulus.txt", stim);
        while (num_recs < MAX_RECS && field_of(num_recs, F_KIND) !== KIND_END) begin
            num_recs++;
        end
        assert (num_recs > 0 && num_recs < MAX_RECS)
            else abort_run("stimulus file missing or without an end record");
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        rec = 0;
        gap = 0;
        while (rec < num_recs) begin
            @(posedge clk);
            #1;
            in_valid       = 1'b0;
            redirect_valid = 1'b0;
            kind           = field_of(rec, F_KIND);
            if (kind == KIND_REDIR) begin
                if (outputs_got == pkts_sent) begin   // pipeline empty
                    redirect_valid = 1'b1;
                    redirect_eip   = field_of(rec, F_PKT);
                    exp_eip        = field_of(rec, F_PKT);
                    rec++;
                end
            end else begin
                assert (kind == KIND_PKT)
                    else abort_run($sformatf("record %0d has an unknown kind", rec));
                if (gap > 0) begin
                    gap--;
                end else if (credits_got > pkts_sent) begin   // holds a credit
                    in_valid  = 1'b1;
                    in_packet = stim[rec*FIELDS + F_PKT];
                    exp_q.push_back(rec);
                    pkts_sent++;
                    rec++;
                    gap = $random(seed) & 3;
                end
            end
        end
        @(posedge clk);
        #1;
        in_valid       = 1'b0;
        redirect_valid = 1'b0;

        // drain whatever is still in the pipe
        while (outputs_got < pkts_sent) begin
            @(posedge clk);
            #1;
        end
        assert (i_dut.i_decode_sva.fail_count == 0)
            else abort_run("a bound assertion on the handshake failed");
        if (exp_q.size() == 0 && outputs_got == pkts_sent) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("packets went missing in the pipeline");
        end
    end

endmodule

// File: sim/decode_sva.sv
module decode_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 in_credit,
    input logic                 out_valid,
    input decode_pkg::decoded_t out_item
);

    int fail_count = 0;   // assertions failed so far

    ////////////////////
    // pipeline timing
    ////////////////////

    // three register stages from fetch to queue
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 out_valid)
        else begin
            $error("out_valid missing 3 cycles after in_valid");
            fail_count++;
        end

    // nothing comes out that was not sent in
    a_no_stray_out: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 3))
        else begin
            $error("out_valid without a packet 3 cycles earlier");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !in_credit && !out_valid)
        else begin
            $error("in_credit or out_valid high during reset");
            fail_count++;
        end

    a_length_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_item.length inside {[1:15]})
        else begin
            $error("decoded length outside 1..15");
            fail_count++;
        end

endmodule

// top level handshake only
bind decode_top decode_sva i_decode_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_item  (out_item)
);

// File: verilog/decode_top.sv
`include "decode_config.svh"

module decode_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  decode_pkg::packet_t   in_packet,
    output logic                  in_credit,
    input  logic                  redirect_valid,
    input  logic [`DEC_EIP_W-1:0] redirect_eip,
    output logic                  out_valid,
    output decode_pkg::decoded_t  out_item,
    input  logic                  out_credit
);

    logic                     s1_valid;   // prefix / opcode done
    decode_pkg::opcode_item_t s1_item;
    logic                     s2_valid;   // length done
    decode_pkg::decoded_t     s2_item;

    ////////////////////
    // pipeline
    ////////////////////

    prefix_opcode_stage i_prefix_opcode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_packet (in_packet),
        .s1_valid  (s1_valid),
        .s1_item   (s1_item)
    );

    modrm_length_stage i_modrm_length (
        .clk       (clk),
        .rst_n     (rst_n),
        .s1_valid  (s1_valid),
        .s1_item   (s1_item),
        .s2_valid  (s2_valid),
        .s2_item   (s2_item)
    );

    eip_stage i_eip (
        .clk            (clk),
        .rst_n          (rst_n),
        .s2_valid       (s2_valid),
        .s2_item        (s2_item),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .out_valid      (out_valid),
        .out_item       (out_item)
    );

    // every accepted packet already owns a queue slot
    credit_pool i_credit_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_credit (out_credit),
        .in_credit  (in_credit)
    );

endmodule

// File: verilog/credit_pool.sv
`include "decode_config.svh"

module credit_pool (
    input  logic clk,
    input  logic rst_n,
    input  logic out_credit,   // queue freed a slot
    output logic in_credit     // one packet slot to fetch
);

    logic [`DEC_POOL_W-1:0] free_cnt;   // queue slots not yet promised
    logic                   issue;

    // hand out a credit whenever a slot is unpromised
    assign issue = (free_cnt != '0);

    ////////////////////
    // slot counter
    ////////////////////

    // issue and return in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_cnt  <= `DEC_POOL_W'(`DEC_QUEUE_DEPTH);   // pool full
            in_credit <= 1'b0;
        end else begin
            free_cnt  <= free_cnt - `DEC_POOL_W'(issue) + `DEC_POOL_W'(out_credit);
            in_credit <= issue;   // pulse one cycle later
        end
    end

endmodule

// File: verilog/eip_stage.sv
`include "decode_config.svh"

module eip_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   s2_valid,
    input  decode_pkg::decoded_t   s2_item,
    input  logic                   redirect_valid,
    input  logic [`DEC_EIP_W-1:0]  redirect_eip,
    output logic                   out_valid,
    output decode_pkg::decoded_t   out_item
);

    logic [`DEC_EIP_W-1:0] eip_q;     // eip of the next item
    logic [`DEC_EIP_W-1:0] eip_next;
    decode_pkg::decoded_t  stamped;

    ////////////////////
    // eip tracking
    ////////////////////

    always_comb begin
        stamped     = s2_item;
        stamped.eip = eip_q;   // current eip, even on a redirect cycle
    end

    // redirect beats the length advance
    always_comb begin
        eip_next = eip_q;
        if (redirect_valid) begin
            eip_next = redirect_eip;
        end else if (s2_valid) begin
            eip_next = eip_q + `DEC_EIP_W'(s2_item.length);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eip_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            eip_q     <= eip_next;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            out_item <= stamped;   // output reg
        end
    end

endmodule

// File: verilog/modrm_length_stage.sv
`include "decode_config.svh"

module modrm_length_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     s1_valid,
    input  decode_pkg::opcode_item_t s1_item,
    output logic                     s2_valid,
    output decode_pkg::decoded_t     s2_item
);

    decode_pkg::byte_idx_t  modrm_off;  // first byte after the opcode
    decode_pkg::byte_idx_t  disp_off;
    decode_pkg::byte_idx_t  imm_off;
    decode_pkg::modrm_sib_u modrm_b;    // read as modrm
    decode_pkg::modrm_sib_u sib_b;      // next byte, read as sib
    logic                   has_sib;
    logic [`DEC_LEN_W-1:0]  disp_len;   // 0, 1 or 4
    logic [`DEC_LEN_W-1:0]  imm_len;    // 0, 1, 2 or 4
    logic [31:0]            disp_raw;   // 4 bytes little endian
    logic [31:0]            imm_raw;
    decode_pkg::decoded_t   dec;

    ////////////////////
    // modrm / sib
    ////////////////////

    always_comb begin
        modrm_off = decode_pkg::byte_idx_t'(s1_item.prefix.count) + 1'b1
                  + decode_pkg::byte_idx_t'(s1_item.is_double);
        modrm_b   = decode_pkg::byte_at(s1_item.packet, modrm_off);
        sib_b     = decode_pkg::byte_at(s1_item.packet, modrm_off + 1'b1);

        // rm 100 with memory operand means sib follows
        has_sib = s1_item.has_modrm && modrm_b.modrm.rm == 3'b100
               && modrm_b.modrm.mod != 2'b11;

        disp_len = '0;
        if (s1_item.has_modrm) begin
            case (modrm_b.modrm.mod)
                2'b01: disp_len = `DEC_LEN_W'(1);
                2'b10: disp_len = `DEC_LEN_W'(4);
                2'b00: begin
                    if (!has_sib && modrm_b.modrm.rm == 3'b101) begin
                        disp_len = `DEC_LEN_W'(4);  // disp32 only
                    end else if (has_sib && sib_b.sib.base == 3'b101) begin
                        disp_len = `DEC_LEN_W'(4);  // index + disp32
                    end
                end
                default: disp_len = '0;          // register operand
            endcase
        end

        case (s1_item.imm_kind)
            decode_pkg::IMM_BYTE:   imm_len = `DEC_LEN_W'(1);
            decode_pkg::IMM_FULL:   imm_len = `DEC_LEN_W'(4);
            decode_pkg::IMM_FULL16: imm_len = `DEC_LEN_W'(2);
            default:                imm_len = '0;
        endcase

        disp_off = modrm_off + decode_pkg::byte_idx_t'(s1_item.has_modrm)
                 + decode_pkg::byte_idx_t'(has_sib);
        imm_off  = disp_off + decode_pkg::byte_idx_t'(disp_len);

        disp_raw = {decode_pkg::byte_at(s1_item.packet, disp_off + 2'd3),
                    decode_pkg::byte_at(s1_item.packet, disp_off + 2'd2),
                    decode_pkg::byte_at(s1_item.packet, disp_off + 2'd1),
                    decode_pkg::byte_at(s1_item.packet, disp_off)};
        imm_raw  = {decode_pkg::byte_at(s1_item.packet, imm_off + 2'd3),
                    decode_pkg::byte_at(s1_item.packet, imm_off + 2'd2),
                    decode_pkg::byte_at(s1_item.packet, imm_off + 2'd1),
                    decode_pkg::byte_at(s1_item.packet, imm_off)};
    end

    ////////////////////
    // output record
    ////////////////////

    always_comb begin
        dec            = '0;   // eip stamped in stage 3
        dec.prefix     = s1_item.prefix;
        dec.opcode     = s1_item.opcode;
        dec.is_double  = s1_item.is_double;
        dec.bad_opcode = s1_item.bad_opcode;

        if (s1_item.has_modrm) begin
            dec.reg_field = modrm_b.modrm.reg_op;
            dec.base      = has_sib ? sib_b.sib.base : modrm_b.modrm.rm;
            dec.use_base  = !(modrm_b.modrm.mod == 2'b00 && disp_len != '0);  // no disp32-only base
            dec.index     = has_sib ? sib_b.sib.index : 3'b000;
            dec.scale     = has_sib ? sib_b.sib.scale : 2'b00;
            dec.use_index = has_sib && sib_b.sib.index != 3'b100;
        end else begin
            dec.reg_field = s1_item.opcode[2:0];  // b8-bf register
        end

        case (disp_len)
            `DEC_LEN_W'(1): dec.disp = {{(`DEC_DISP_W-8){disp_raw[7]}}, disp_raw[7:0]};
            `DEC_LEN_W'(4): dec.disp = `DEC_DISP_W'(disp_raw);
            default:        dec.disp = '0;
        endcase

        case (s1_item.imm_kind)
            decode_pkg::IMM_BYTE:   dec.imm = {{(`DEC_IMM_W-8){imm_raw[7]}}, imm_raw[7:0]};
            decode_pkg::IMM_FULL:   dec.imm = `DEC_IMM_W'(imm_raw);
            decode_pkg::IMM_FULL16: dec.imm = {{(`DEC_IMM_W-16){1'b0}}, imm_raw[15:0]};
            default:                dec.imm = '0;
        endcase

        // prefixes + opcode + modrm + sib + disp, then imm
        if (s1_item.bad_opcode) begin
            dec.length = `DEC_LEN_W'(1);
        end else begin
            dec.length = `DEC_LEN_W'(imm_off) + imm_len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_item <= dec;
        end
    end

endmodule

// File: verilog/prefix_opcode_stage.sv
`include "decode_config.svh"

module prefix_opcode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  decode_pkg::packet_t      in_packet,
    output logic                     s1_valid,
    output decode_pkg::opcode_item_t s1_item
);

    decode_pkg::prefix_info_t pfx;        // scan result
    logic                     pfx_done;   // first non-prefix byte seen
    logic [7:0]               pfx_byte;
    decode_pkg::byte_idx_t    op_idx;     // opcode position
    logic [7:0]               op_first;
    logic [7:0]               op_second;  // only used after 0f
    decode_pkg::opcode_item_t item;

    ////////////////////
    // prefix scan
    ////////////////////

    // stops at the first byte that is not a prefix
    always_comb begin
        pfx      = '0;
        pfx_done = 1'b0;
        pfx_byte = 8'h00;
        for (int i = 0; i < `DEC_MAX_PREFIX; i++) begin
            pfx_byte = decode_pkg::byte_at(in_packet, decode_pkg::byte_idx_t'(i));
            if (!pfx_done) begin
                case (pfx_byte)
                    8'hF3: pfx.rep    = 1'b1;
                    8'h66: pfx.opsize = 1'b1;
                    8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65: begin
                        pfx.seg_valid = 1'b1;   // last override wins
                        // 26/2e/36/3e from bits 4:3, 64/65 from bit 0
                        pfx.seg = {pfx_byte[6],
                                   pfx_byte[6] ? {1'b0, pfx_byte[0]} : pfx_byte[4:3]};
                    end
                    default: pfx_done = 1'b1;
                endcase
                if (!pfx_done) begin
                    pfx.count = pfx.count + 2'd1;
                end
            end
        end
    end

    ////////////////////
    // opcode classify
    ////////////////////

    always_comb begin
        op_idx    = decode_pkg::byte_idx_t'(pfx.count);
        op_first  = decode_pkg::byte_at(in_packet, op_idx);
        op_second = decode_pkg::byte_at(in_packet, op_idx + 1'b1);

        item        = '0;   // no modrm, no imm, not bad
        item.packet = in_packet;
        item.prefix = pfx;
        item.opcode = op_first;

        case (op_first) inside
            8'h0F: begin
                item.is_double = 1'b1;
                item.opcode    = op_second;
                if (op_second == 8'hAF) begin   // imul r, r/m
                    item.has_modrm = 1'b1;
                end else begin
                    item.bad_opcode = 1'b1;
                end
            end
            8'h01, 8'h03, 8'h89, 8'h8B: begin  // add / mov, r/m forms
                item.has_modrm = 1'b1;
            end
            8'hC7, 8'h81: begin                // mov / alu r/m, imm32
                item.has_modrm = 1'b1;
                item.imm_kind  = decode_pkg::IMM_FULL;
            end
            8'h83: begin                       // alu r/m, imm8
                item.has_modrm = 1'b1;
                item.imm_kind  = decode_pkg::IMM_BYTE;
            end
            8'h90, 8'hC3: begin
                // nop, ret, opcode byte only
            end
            8'h05, [8'hB8:8'hBF], 8'hE9: begin // add eax, mov r, jmp rel32
                item.imm_kind = decode_pkg::IMM_FULL;
            end
            8'hEB: begin                       // jmp rel8
                item.imm_kind = decode_pkg::IMM_BYTE;
            end
            default: begin
                item.bad_opcode = 1'b1;
            end
        endcase

        // 66 shrinks a full imm to 2 bytes
        if (item.imm_kind == decode_pkg::IMM_FULL && pfx.opsize) begin
            item.imm_kind = decode_pkg::IMM_FULL16;
        end
    end

    ////////////////////
    // stage register
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_item <= item;
        end
    end

endmodule

// File: verilog/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

    typedef logic [`DEC_PACKET_BYTES*8-1:0]       packet_t;    // byte 0 in the top bits
    typedef logic [$clog2(`DEC_PACKET_BYTES)-1:0] byte_idx_t;  // offset into a packet

    // immediate class, full16 is a full immediate shortened by 66
    typedef enum logic [1:0] {
        IMM_NONE   = 2'd0,
        IMM_BYTE   = 2'd1,
        IMM_FULL   = 2'd2,
        IMM_FULL16 = 2'd3
    } imm_kind_e;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_op;     // register or opcode extension
        logic [2:0] rm;
    } modrm_t;

    typedef struct packed {
        logic [1:0] scale;
        logic [2:0] index;      // 100 means no index
        logic [2:0] base;
    } sib_t;

    // one address byte, ModRM at its own offset and SIB one further on
    typedef union packed {
        modrm_t modrm;
        sib_t   sib;
    } modrm_sib_u;

    typedef struct packed {
        logic       rep;        // f3
        logic       opsize;     // 66
        logic       seg_valid;
        logic [2:0] seg;        // es cs ss ds fs gs = 0..5
        logic [1:0] count;
    } prefix_info_t;

    typedef struct packed {
        packet_t      packet;
        prefix_info_t prefix;
        logic [7:0]   opcode;     // second byte when is_double
        logic         is_double;  // 0f escape
        logic         has_modrm;
        imm_kind_e    imm_kind;
        logic         bad_opcode;
    } opcode_item_t;

    typedef struct packed {
        prefix_info_t            prefix;
        logic [7:0]              opcode;
        logic                    is_double;
        logic                    bad_opcode;
        logic [`DEC_LEN_W-1:0]   length;
        logic [2:0]              reg_field;
        logic [2:0]              base;
        logic [2:0]              index;
        logic [1:0]              scale;
        logic                    use_base;
        logic                    use_index;
        logic [`DEC_DISP_W-1:0]  disp;
        logic [`DEC_IMM_W-1:0]   imm;      // rel offset for e9 / eb
        logic [`DEC_EIP_W-1:0]   eip;
    } decoded_t;

    // byte idx of a packet, idx 0 sits in the top bits
    function automatic logic [7:0] byte_at(input packet_t pkt, input byte_idx_t idx);
        return pkt[(`DEC_PACKET_BYTES - 1 - idx) * 8 +: 8];
    endfunction

endpackage

// File: verilog/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// fetch packet
`define DEC_PACKET_BYTES 16     // byte 0 starts an instruction

// datapath widths
`define DEC_EIP_W        32
`define DEC_DISP_W       32
`define DEC_IMM_W        32
`define DEC_LEN_W        4      // max length 15
`define DEC_MAX_PREFIX   3      // prefixes scanned ahead of the opcode

// downstream queue and credits
`define DEC_QUEUE_DEPTH  4
`define DEC_POOL_W       3      // must hold DEC_QUEUE_DEPTH

`endif
